// ==== collator_pkg.sv ====
`default_nettype none

package collator_pkg;

	localparam int BUF_DEPTH_DEF = 64;

	// groups 5 down to 0, motion signs come first as group 6
	localparam int GROUP_COUNT = 6;

	typedef logic [2:0] group_t;
	typedef logic [5:0] pos_t;
	typedef logic [6:0] count_t;
	typedef logic [2:0] motion_count_t;

	localparam group_t MOTION_GROUP = 3'd6;

	typedef enum logic [1:0] {
		SIGN         = 2'd0,
		GROUP_CHANGE = 2'd1,
		MB_END       = 2'd2,
		SLICE_END    = 2'd3
	} event_kind_e;

	// sign is only meaningful for SIGN events
	typedef struct packed {
		event_kind_e kind;
		logic        sign;
	} sign_event_t;

	typedef struct packed {
		logic   sign;
		group_t group;
		pos_t   pos;
	} buf_entry_t;

	typedef struct packed {
		count_t plain;
		count_t non_plain;
	} group_count_t;

	// 4 + 3 + 6 * 14 = 91 bits, group 5 in the upper bits
	typedef struct packed {
		logic [3:0]                         reserved;
		motion_count_t                      motion;
		group_count_t [GROUP_COUNT-1:0]     groups;
	} mb_conf_t;

	typedef struct packed {
		mb_conf_t conf;
		count_t   fill;
		group_t   first_group;
		logic     has_one_group;
		logic     no_sign;
	} mb_record_t;

endpackage

`default_nettype wire

// ==== group_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module group_counters import collator_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     cnt_en,
	input  group_t   cnt_group,
	input  logic     cnt_plain,
	input  logic     clear,
	output mb_conf_t conf
);

	count_t        plain_cnt     [GROUP_COUNT];
	count_t        non_plain_cnt [GROUP_COUNT];
	motion_count_t motion_cnt;

	logic [GROUP_COUNT-1:0] grp_hit;
	logic                   motion_hit;

	// route the strobe by group number
	always_comb begin
		for (int g = 0; g < GROUP_COUNT; g++) begin
			grp_hit[g] = cnt_en && (cnt_group == group_t'(g));
		end
	end

	// non-plaintext motion signs are not counted
	assign motion_hit = cnt_en && cnt_plain && (cnt_group == MOTION_GROUP);

	always_ff @(posedge clk) begin
		if (!rst || clear) begin
			for (int g = 0; g < GROUP_COUNT; g++) begin
				plain_cnt[g]     <= '0;
				non_plain_cnt[g] <= '0;
			end
		end else begin
			for (int g = 0; g < GROUP_COUNT; g++) begin
				// saturate rather than wrap on long macroblocks
				if (grp_hit[g] && cnt_plain && plain_cnt[g] != '1) begin
					plain_cnt[g] <= plain_cnt[g] + 7'd1;
				end
				if (grp_hit[g] && !cnt_plain && non_plain_cnt[g] != '1) begin
					non_plain_cnt[g] <= non_plain_cnt[g] + 7'd1;
				end
			end
		end
	end

	// motion count stops at 7
	always_ff @(posedge clk) begin
		if (!rst || clear) begin
			motion_cnt <= '0;
		end else if (motion_hit && motion_cnt != '1) begin
			motion_cnt <= motion_cnt + 3'd1;
		end
	end

	always_comb begin
		conf.reserved = '0;
		conf.motion   = motion_cnt;
		for (int g = 0; g < GROUP_COUNT; g++) begin
			conf.groups[g].plain     = plain_cnt[g];
			conf.groups[g].non_plain = non_plain_cnt[g];
		end
	end

endmodule

`default_nettype wire

// ==== sign_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sign_buffer import collator_pkg::*; #(
	parameter int BUF_DEPTH = BUF_DEPTH_DEF
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         wr_en,
	input  count_t                       wr_idx,
	input  buf_entry_t                   wr_entry,
	output buf_entry_t [BUF_DEPTH-1:0]   entries
);

	logic [BUF_DEPTH-1:0] wr_sel;

	// one-hot write decode
	always_comb begin
		for (int i = 0; i < BUF_DEPTH; i++) begin
			wr_sel[i] = wr_en && (wr_idx == count_t'(i));
		end
	end

	// entries above the fill level keep stale data
	always_ff @(posedge clk) begin
		if (!rst) begin
			entries <= '0;
		end else begin
			for (int i = 0; i < BUF_DEPTH; i++) begin
				if (wr_sel[i]) begin
					entries[i] <= wr_entry;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== collator_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module collator_ctrl import collator_pkg::*; #(
	parameter int BUF_DEPTH = BUF_DEPTH_DEF
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        ev_valid,
	input  sign_event_t ev,
	output logic        ev_ready,
	output logic        rec_valid,
	output mb_record_t  rec,
	input  logic        rec_ready,
	input  mb_conf_t    conf,
	output logic        wr_en,
	output count_t      wr_idx,
	output buf_entry_t  wr_entry,
	output logic        cnt_en,
	output group_t      cnt_group,
	output logic        cnt_plain,
	output logic        clear
);

	localparam count_t DEPTH = count_t'(BUF_DEPTH);

	// per-macroblock state
	group_t cur_group;
	pos_t   arr_pos;
	count_t fill;
	group_t first_group;
	logic   one_group;

	logic   ev_fire;
	logic   rec_fire;
	logic   is_sign;
	logic   is_gchg;
	logic   is_end;
	logic   is_slice_end;
	logic   empty;
	logic   has_room;
	logic   make_rec;
	logic   drop_mb;
	group_t sign_rank;

	// no new events while a record waits
	assign ev_ready = !rec_valid;

	assign ev_fire  = ev_valid && ev_ready;
	assign rec_fire = rec_valid && rec_ready;

	assign is_sign      = ev_fire && (ev.kind == SIGN);
	assign is_gchg      = ev_fire && (ev.kind == GROUP_CHANGE);
	assign is_slice_end = ev_fire && (ev.kind == SLICE_END);
	assign is_end       = ev_fire && (ev.kind == MB_END || ev.kind == SLICE_END);

	assign empty    = (fill == '0);
	assign has_room = (fill < DEPTH);

	// an empty MB_END is swallowed, an empty SLICE_END still reports
	assign make_rec = is_end && (!empty || is_slice_end);
	assign drop_mb  = is_end && !make_rec;

	// 0 for motion, 6 for group 0
	assign sign_rank = MOTION_GROUP - cur_group;

	// arrival order placement, overflow becomes non-plaintext
	assign wr_en    = is_sign && has_room;
	assign wr_idx   = fill;
	assign wr_entry = '{sign: ev.sign, group: cur_group, pos: arr_pos};

	assign cnt_en    = is_sign;
	assign cnt_group = cur_group;
	assign cnt_plain = has_room;

	// counters clear on the same edge as the local state
	assign clear = rec_fire || drop_mb;

	always_ff @(posedge clk) begin
		if (!rst || clear) begin
			cur_group   <= MOTION_GROUP;
			arr_pos     <= '0;
			fill        <= '0;
			first_group <= '0;
			one_group   <= 1'b1;
		end else if (is_gchg) begin
			// stays at group 0 once there
			if (cur_group != '0) begin
				cur_group <= cur_group - 3'd1;
			end
		end else if (is_sign) begin
			if (arr_pos != '1) begin
				arr_pos <= arr_pos + 6'd1;
			end
			if (has_room) begin
				fill <= fill + 7'd1;
			end
			if (empty) begin
				first_group <= sign_rank;
			end else if (sign_rank != first_group) begin
				one_group <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			rec_valid <= 1'b0;
		end else if (make_rec) begin
			rec_valid <= 1'b1;
		end else if (rec_fire) begin
			rec_valid <= 1'b0;
		end
	end

	// state is frozen while rec_valid is high, so the record holds
	always_comb begin
		rec.conf          = conf;
		rec.fill          = fill;
		rec.first_group   = first_group;
		rec.has_one_group = one_group;
		rec.no_sign       = empty;
	end

endmodule

`default_nettype wire

// ==== collator_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module collator_top import collator_pkg::*; #(
	parameter int BUF_DEPTH = BUF_DEPTH_DEF
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         ev_valid,
	input  sign_event_t                  ev,
	output logic                         ev_ready,
	output logic                         rec_valid,
	output mb_record_t                   rec,
	output buf_entry_t [BUF_DEPTH-1:0]   entries,
	input  logic                         rec_ready
);

	logic       wr_en;
	count_t     wr_idx;
	buf_entry_t wr_entry;
	logic       cnt_en;
	group_t     cnt_group;
	logic       cnt_plain;
	logic       clear;
	mb_conf_t   conf;

	collator_ctrl #(
		.BUF_DEPTH(BUF_DEPTH)
	) u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.ev_valid  (ev_valid),
		.ev        (ev),
		.ev_ready  (ev_ready),
		.rec_valid (rec_valid),
		.rec       (rec),
		.rec_ready (rec_ready),
		.conf      (conf),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_entry  (wr_entry),
		.cnt_en    (cnt_en),
		.cnt_group (cnt_group),
		.cnt_plain (cnt_plain),
		.clear     (clear)
	);

	sign_buffer #(
		.BUF_DEPTH(BUF_DEPTH)
	) u_buffer (
		.clk      (clk),
		.rst      (rst),
		.wr_en    (wr_en),
		.wr_idx   (wr_idx),
		.wr_entry (wr_entry),
		.entries  (entries)
	);

	group_counters u_counters (
		.clk       (clk),
		.rst       (rst),
		.cnt_en    (cnt_en),
		.cnt_group (cnt_group),
		.cnt_plain (cnt_plain),
		.clear     (clear),
		.conf      (conf)
	);

endmodule

`default_nettype wire

// ==== collator_tb_tasks.svh ====
`ifndef COLLATOR_TB_TASKS_SVH
`define COLLATOR_TB_TASKS_SVH

task automatic model_clear();
	m_group  = MOTION_GROUP;
	m_pos    = 0;
	m_fill   = 0;
	m_first  = '0;
	m_seen   = 1'b0;
	m_one    = 1'b1;
	m_motion = '0;
	for (int g = 0; g < GROUP_COUNT; g++) begin
		m_plain[g]     = '0;
		m_non_plain[g] = '0;
	end
endtask

task automatic model_event(sign_event_t e);
	logic   plain;
	group_t rank;
	case (e.kind)
		GROUP_CHANGE: begin
			if (m_group != 3'd0) begin
				m_group = m_group - 3'd1;
			end
		end
		SIGN: begin
			plain = (m_fill < BUF_DEPTH);
			rank  = MOTION_GROUP - m_group;
			if (!m_seen) begin
				m_first = rank;
				m_seen  = 1'b1;
			end else if (rank != m_first) begin
				m_one = 1'b0;
			end
			if (plain) begin
				m_entries[m_fill].sign  = e.sign;
				m_entries[m_fill].group = m_group;
				m_entries[m_fill].pos   = pos_t'(m_pos);
				m_fill++;
			end
			if (m_group == MOTION_GROUP) begin
				if (plain && m_motion != 3'd7) begin
					m_motion = m_motion + 3'd1;
				end
			end else if (plain) begin
				m_plain[m_group] = m_plain[m_group] + 7'd1;
			end else begin
				m_non_plain[m_group] = m_non_plain[m_group] + 7'd1;
			end
			if (m_pos < 63) begin
				m_pos++;
			end
		end
		MB_END: begin
			// empty macroblock is dropped without a record
			if (m_fill == 0) begin
				model_clear();
			end
		end
		default: begin
		end
	endcase
endtask

function automatic mb_conf_t expected_conf();
	mb_conf_t c;
	c        = '0;
	c.motion = m_motion;
	for (int g = 0; g < GROUP_COUNT; g++) begin
		c.groups[g].plain     = m_plain[g];
		c.groups[g].non_plain = m_non_plain[g];
	end
	return c;
endfunction

function automatic mb_record_t expected_record();
	mb_record_t r;
	r.conf          = expected_conf();
	r.fill          = count_t'(m_fill);
	r.first_group   = m_first;
	r.has_one_group = m_one;
	r.no_sign       = (m_fill == 0);
	return r;
endfunction

function automatic logic random_bit();
	return ($urandom & 1) != 0;
endfunction

task automatic check_record(mb_record_t got, mb_record_t exp, string what);
	if (got !== exp) begin
		fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
	end
endtask

task automatic check_entry(buf_entry_t got, buf_entry_t exp, int idx);
	if (got !== exp) begin
		fail_run($sformatf(
			"error at %0t: entry %0d is sign %b group %0d pos %0d, expected %b %0d %0d",
			$time, idx, got.sign, got.group, got.pos, exp.sign, exp.group, exp.pos));
	end
endtask

task automatic check_conf(mb_conf_t got, mb_conf_t exp, string what);
	if (got !== exp) begin
		fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
	end
endtask

task automatic check_count(count_t got, count_t exp, string what);
	if (got !== exp) begin
		fail_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
	end
endtask

task automatic check_flag(logic got, logic exp, string what);
	if (got !== exp) begin
		fail_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
	end
endtask

task automatic send_event(event_kind_e kind, logic sign);
	sign_event_t e;
	int          waited;
	e.kind = kind;
	e.sign = sign;
	waited = 0;
	while (!ev_ready) begin
		@(posedge clk);
		#1;
		waited++;
		if (waited > WAIT_LIMIT) begin
			fail_run("timed out waiting for ev_ready to accept an event");
		end
	end
	ev       = e;
	ev_valid = 1'b1;
	@(posedge clk);
	#1;
	ev_valid = 1'b0;
	ev       = '0;
	model_event(e);
endtask

task automatic wait_record();
	int waited;
	waited = 0;
	while (!rec_valid) begin
		@(posedge clk);
		#1;
		waited++;
		if (waited > WAIT_LIMIT) begin
			fail_run("timed out waiting for rec_valid after an end event");
		end
	end
endtask

task automatic take_record();
	wait_record();
	last_rec     = rec;
	last_entries = entries;
	check_record(rec, expected_record(), "record");
	for (int i = 0; i < m_fill; i++) begin
		check_entry(entries[i], m_entries[i], i);
	end
	rec_ready = 1'b1;
	@(posedge clk);
	#1;
	rec_ready = 1'b0;
	check_flag(rec_valid, 1'b0, "rec_valid after transfer");
	check_flag(ev_ready, 1'b1, "ev_ready after transfer");
	model_clear();
endtask

task automatic mixed_motion_group5();
	mb_conf_t c;
	repeat (5) send_event(SIGN, random_bit());
	send_event(GROUP_CHANGE, 1'b0);
	repeat (3) send_event(SIGN, random_bit());
	send_event(MB_END, 1'b0);
	take_record();
	c                 = '0;
	c.motion          = 3'd5;
	c.groups[5].plain = 7'd3;
	check_conf(last_rec.conf, c, "conf of mixed macroblock");
	check_count(last_rec.fill, 7'd8, "fill of mixed macroblock");
	check_count(count_t'(last_rec.first_group), 7'd0, "first_group of mixed macroblock");
	check_flag(last_rec.has_one_group, 1'b0, "has_one_group of mixed macroblock");
	for (int i = 0; i < 8; i++) begin
		check_count(count_t'(last_entries[i].pos), count_t'(i), "entry position");
	end
endtask

task automatic late_first_sign();
	repeat (2) send_event(GROUP_CHANGE, 1'b0);
	repeat (3) send_event(SIGN, random_bit());
	send_event(MB_END, 1'b0);
	take_record();
	check_count(count_t'(last_rec.first_group), 7'd2, "first_group after two changes");
	check_flag(last_rec.has_one_group, 1'b1, "has_one_group of group 4 macroblock");
endtask

task automatic overflow_group3();
	mb_conf_t c;
	repeat (3) send_event(GROUP_CHANGE, 1'b0);
	repeat (70) send_event(SIGN, random_bit());
	send_event(MB_END, 1'b0);
	take_record();
	c                     = '0;
	c.groups[3].plain     = 7'd64;
	c.groups[3].non_plain = 7'd6;
	check_conf(last_rec.conf, c, "conf of overflowing macroblock");
	check_count(last_rec.fill, 7'd64, "fill of overflowing macroblock");
	check_count(count_t'(last_entries[63].pos), 7'd63, "position of entry 63");
endtask

task automatic empty_ends();
	send_event(MB_END, 1'b0);
	// no record may show up for an empty MB_END
	for (int i = 0; i < WAIT_LIMIT; i++) begin
		@(posedge clk);
		#1;
		check_flag(rec_valid, 1'b0, "rec_valid after empty MB_END");
	end
	send_event(SLICE_END, 1'b0);
	take_record();
	check_flag(last_rec.no_sign, 1'b1, "no_sign of empty slice end");
	check_conf(last_rec.conf, '0, "conf of empty slice end");
endtask

task automatic record_backpressure();
	mb_conf_t   c;
	mb_record_t held;
	int         hold;
	hold = 3 + int'($urandom % 8);
	repeat (4) send_event(SIGN, random_bit());
	send_event(MB_END, 1'b0);
	wait_record();
	held = rec;
	repeat (hold) begin
		@(posedge clk);
		#1;
		check_record(rec, held, "record under back-pressure");
		check_flag(ev_ready, 1'b0, "ev_ready under back-pressure");
		check_flag(rec_valid, 1'b1, "rec_valid under back-pressure");
	end
	take_record();
	check_count(last_rec.fill, 7'd4, "fill of held record");
	// next macroblock must start from cleared counts
	send_event(GROUP_CHANGE, 1'b0);
	send_event(SIGN, random_bit());
	send_event(MB_END, 1'b0);
	take_record();
	c                 = '0;
	c.groups[5].plain = 7'd1;
	check_conf(last_rec.conf, c, "conf after back-pressure");
	check_count(last_rec.fill, 7'd1, "fill after back-pressure");
endtask

task automatic motion_saturation();
	mb_conf_t c;
	repeat (9) send_event(SIGN, random_bit());
	send_event(MB_END, 1'b0);
	take_record();
	c        = '0;
	c.motion = 3'd7;
	check_conf(last_rec.conf, c, "conf with nine motion signs");
	check_count(last_rec.fill, 7'd9, "fill with nine motion signs");
endtask

`endif

// ==== collator_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module collator_tb import collator_pkg::*; ();

	localparam int BUF_DEPTH  = BUF_DEPTH_DEF;
	localparam int WAIT_LIMIT = 200;
	localparam int SEED       = 48087;

	logic        clk;
	logic        rst;
	logic        ev_valid;
	sign_event_t ev;
	logic        ev_ready;
	logic        rec_valid;
	mb_record_t  rec;
	logic        rec_ready;

	buf_entry_t [BUF_DEPTH-1:0] entries;

	// reference model state for the current macroblock
	group_t        m_group;
	int            m_pos;
	int            m_fill;
	group_t        m_first;
	logic          m_seen;
	logic          m_one;
	count_t        m_plain     [GROUP_COUNT];
	count_t        m_non_plain [GROUP_COUNT];
	motion_count_t m_motion;
	buf_entry_t    m_entries   [BUF_DEPTH];

	// copy of the last transferred record
	mb_record_t                 last_rec;
	buf_entry_t [BUF_DEPTH-1:0] last_entries;

	collator_top #(
		.BUF_DEPTH(BUF_DEPTH)
	) dut_i (
		.clk       (clk),
		.rst       (rst),
		.ev_valid  (ev_valid),
		.ev        (ev),
		.ev_ready  (ev_ready),
		.rec_valid (rec_valid),
		.rec       (rec),
		.entries   (entries),
		.rec_ready (rec_ready)
	);

	always #4 clk = ~clk;

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	`include "collator_tb_tasks.svh"

	initial begin
		void'($urandom(SEED));
		clk         = 1'b0;
		rst         = 1'b0;
		ev_valid    = 1'b0;
		ev          = '0;
		rec_ready   = 1'b0;
		model_clear();
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b1;

		mixed_motion_group5();
		late_first_sign();
		overflow_group3();
		empty_ends();
		record_backpressure();
		motion_saturation();

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
collator_pkg.sv
group_counters.sv
sign_buffer.sv
collator_ctrl.sv
collator_top.sv
collator_tb.sv

// ==== Bender.yml ====
package:
  name: collator

sources:
  - collator_pkg.sv
  - group_counters.sv
  - sign_buffer.sv
  - collator_ctrl.sv
  - collator_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - collator_tb.sv
